//--- include/spi_sram_defs.svh
`ifndef SPI_SRAM_DEFS_SVH
`define SPI_SRAM_DEFS_SVH

// burst buffer sizing
`define SRAM_FIFO_DEPTH 32			// max bytes per burst
`define SRAM_CNT_WIDTH 6			// log2(depth)+1, pointers reach depth

// device geometry, 16-bit parts only
`define SRAM_ADDR_WIDTH 16			// must be a multiple of 8
`define SRAM_DUMMY_BYTES 1			// bytes thrown away before read data

// command bytes
`define SRAM_CMD_QUAD_ENTER 8'h38	// sent serially on lane 0
`define SRAM_CMD_WRITE 8'h02		// sequential write
`define SRAM_CMD_READ 8'h03			// sequential read

`endif

//--- hdl/qspi_bus_pkg.sv
package qspi_bus_pkg;

	// four pulses per SPI clock, sck is high in the upper two
	typedef enum logic [1:0] {
		PH_LOW0  = 2'd0,	// sck low, bus settles
		PH_LOW1  = 2'd1,	// sck low, controller changes dout
		PH_HIGH0 = 2'd2,	// sck rising, sram latches
		PH_HIGH1 = 2'd3		// sck high, controller samples din
	} phase_e;

	typedef struct packed {
		phase_e ph;			// current pulse
		logic drive_edge;	// first clock of PH_LOW1
		logic sample_edge;	// first clock of PH_HIGH1
	} phase_t;

	typedef struct packed {
		logic [3:0] dout;	// value per lane
		logic [3:0] oe;		// output enable per lane, 1 drives the pin
	} lane_drive_t;

endpackage

//--- hdl/sram_cmd_pkg.sv
`include "spi_sram_defs.svh"

package sram_cmd_pkg;

	typedef enum logic [7:0] {
		OP_WRITE      = `SRAM_CMD_WRITE,
		OP_READ       = `SRAM_CMD_READ,
		OP_QUAD_ENTER = `SRAM_CMD_QUAD_ENTER
	} opcode_e;

	typedef enum logic [3:0] {
		INIT,			// lower cs_n, then load quad entry
		CS_SETUP,		// wait cnt spi cycles, return to tag
		SEND_SERIAL,	// shift cnt bits out on lane 0
		SEND_QUAD,		// shift cnt nibbles out on all lanes
		RECV_QUAD,		// shift cnt nibbles in
		IDLE,			// host owns the fifo
		START_WRITE,
		ADDR_WRITE,
		DATA_WRITE,
		START_READ,
		ADDR_READ,
		DATA_READ,
		HANGUP			// raise cs_n and rest two cycles
	} seq_state_e;

	typedef struct packed {
		logic [`SRAM_ADDR_WIDTH-1:0] addr;	// burst start
		logic [`SRAM_CNT_WIDTH-1:0] size;	// read length in bytes
		logic is_write;						// 1 write, 0 read
	} sram_req_t;

endpackage

//--- hdl/qspi_phase_gen.sv
`timescale 1ns/1ps

module qspi_phase_gen (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,		// step the phase while high
	input  logic [15:0]          bauddiv,	// clocks per phase, minus one
	output qspi_bus_pkg::phase_t phase,
	output logic                 sck
);

	logic [15:0] timer;						// clocks left in this phase
	qspi_bus_pkg::phase_e ph;				// current phase
	qspi_bus_pkg::phase_e prev_ph;			// phase one clock ago, for edge strobes

	always_ff @(posedge clk) begin
		if (!rst_n || !run) begin
			timer   <= bauddiv;				// park at the start of a cycle
			ph      <= qspi_bus_pkg::PH_LOW0;
			prev_ph <= qspi_bus_pkg::PH_LOW0;	// equal to ph so no strobe fires
		end else begin
			prev_ph <= ph;
			if (timer == 16'd0) begin
				timer <= bauddiv;			// reload for the next phase
				ph    <= qspi_bus_pkg::phase_e'(ph + 2'd1);	// wraps HIGH1 -> LOW0
			end else begin
				timer <= timer - 16'd1;
			end
		end
	end

	// strobes fire on the first clock of a phase only
	always_comb begin
		phase.ph          = ph;
		phase.drive_edge  = (ph == qspi_bus_pkg::PH_LOW1) &&
			(prev_ph != qspi_bus_pkg::PH_LOW1);
		phase.sample_edge = (ph == qspi_bus_pkg::PH_HIGH1) &&
			(prev_ph != qspi_bus_pkg::PH_HIGH1);
	end

	assign sck = (ph == qspi_bus_pkg::PH_HIGH0) ||
		(ph == qspi_bus_pkg::PH_HIGH1);		// high for the second half cycle

endmodule

//--- hdl/burst_fifo.sv
`timescale 1ns/1ps
`include "spi_sram_defs.svh"

module burst_fifo (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       owner,		// 1 sequencer side, 0 host side
	input  logic                       push,		// host write strobe
	input  logic [7:0]                 push_data,
	input  logic                       pop,			// host read strobe
	input  logic                       eng_push,	// sequencer write strobe
	input  logic [7:0]                 eng_data,
	input  logic                       eng_pop,		// sequencer read strobe
	input  logic                       rewind_rd,	// read pointer back to 0
	input  logic                       clear_wr,	// write pointer back to 0
	output logic [7:0]                 head,		// byte at read pointer
	output logic [`SRAM_CNT_WIDTH-1:0] count,		// bytes written since clear
	output logic                       drained		// read pointer caught up
);

	localparam int IDX_W = `SRAM_CNT_WIDTH - 1;
	localparam logic [`SRAM_CNT_WIDTH-1:0] DEPTH = `SRAM_CNT_WIDTH'(`SRAM_FIFO_DEPTH);

	logic [7:0] mem [`SRAM_FIFO_DEPTH];			// linear buffer, refilled from 0
	logic [`SRAM_CNT_WIDTH-1:0] wr_ptr;			// stops at depth
	logic [`SRAM_CNT_WIDTH-1:0] rd_ptr;			// stops at wr_ptr
	logic [7:0] wdata;							// selected write byte
	logic do_push;								// accepted write
	logic do_pop;								// accepted read
	logic full;
	logic empty;

	assign full    = (wr_ptr == DEPTH);
	assign empty   = (rd_ptr == wr_ptr);
	assign wdata   = owner ? eng_data : push_data;
	assign do_push = (owner ? eng_push : push) && !full;	// extra bytes are dropped
	assign do_pop  = (owner ? eng_pop : pop) && !empty;	// pops past the end do nothing

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr[IDX_W-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (clear_wr) begin
				wr_ptr <= '0;
			end else if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rewind_rd) begin
				rd_ptr <= '0;					// wins over a same-cycle pop
			end else if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	assign head    = mem[rd_ptr[IDX_W-1:0]];	// wraps to 0 once rd_ptr hits depth
	assign count   = wr_ptr;
	assign drained = empty;

endmodule

//--- hdl/spi_sram.sv
`timescale 1ns/1ps
`include "spi_sram_defs.svh"

module spi_sram (
	input  logic                       clk,
	input  logic                       rst_n,
	input  sram_cmd_pkg::sram_req_t    req,			// sampled in IDLE
	input  logic                       req_valid,
	output logic                       busy,
	input  qspi_bus_pkg::phase_t       phase,
	output logic                       run,			// enables the phase generator
	output qspi_bus_pkg::lane_drive_t  lanes,
	output logic                       cs_n,
	input  logic [3:0]                 din,			// sio pins as seen by us
	output logic                       owner,
	output logic                       eng_push,
	output logic [7:0]                 eng_data,
	output logic                       eng_pop,
	output logic                       rewind_rd,
	output logic                       clear_wr,
	input  logic [7:0]                 head,
	input  logic [`SRAM_CNT_WIDTH-1:0] count,
	input  logic                       drained
);

	localparam int ADDR_BYTES = `SRAM_ADDR_WIDTH / 8;
	localparam int IDX_W = (ADDR_BYTES > 1) ? $clog2(ADDR_BYTES) : 1;
	localparam int DUMMY_W = $clog2(`SRAM_DUMMY_BYTES + 2);
	localparam logic [`SRAM_CNT_WIDTH-1:0] DEPTH = `SRAM_CNT_WIDTH'(`SRAM_FIFO_DEPTH);

	sram_cmd_pkg::seq_state_e state;
	sram_cmd_pkg::seq_state_e tag;				// where a sub-state returns to
	sram_cmd_pkg::sram_req_t req_q;				// request held for the burst
	logic [7:0] shift;							// byte going out or coming in
	logic [3:0] cnt;							// spi cycles left in a sub-state
	logic [IDX_W-1:0] addr_idx;					// address byte, high first
	logic [DUMMY_W-1:0] dummy_cnt;				// receives to discard
	logic [7:0] addr_byte;
	logic [`SRAM_CNT_WIDTH-1:0] next_count;		// count after this push
	logic rd_last;								// this push ends the read
	logic in_sub;								// counting spi cycles on sample_edge

	assign run   = busy;						// phase resets while idle
	assign owner = busy;						// host has the fifo only when idle

	assign addr_byte  = 8'(req_q.addr >> {addr_idx, 3'b000});
	assign next_count = count + 1'b1;
	assign rd_last    = (next_count >= req_q.size) || (next_count == DEPTH);
	assign in_sub     = state inside {sram_cmd_pkg::CS_SETUP, sram_cmd_pkg::SEND_SERIAL,
		sram_cmd_pkg::SEND_QUAD, sram_cmd_pkg::RECV_QUAD};

	// fifo strobes, each data state lasts exactly one clock
	always_comb begin
		eng_push  = 1'b0;
		eng_pop   = 1'b0;
		rewind_rd = 1'b0;
		clear_wr  = 1'b0;
		case (state)
			sram_cmd_pkg::START_WRITE: begin
				rewind_rd = 1'b1;				// send from index 0
			end
			sram_cmd_pkg::DATA_WRITE: begin
				eng_pop   = !drained;
				rewind_rd = drained;			// burst done, empty the buffer
				clear_wr  = drained;
			end
			sram_cmd_pkg::START_READ: begin
				clear_wr = 1'b1;				// fill from index 0
			end
			sram_cmd_pkg::DATA_READ: begin
				eng_push  = (dummy_cnt == '0);
				rewind_rd = (dummy_cnt == '0) && rd_last;	// host reads from 0
			end
			default: begin
			end
		endcase
	end

	assign eng_data = shift;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= sram_cmd_pkg::INIT;
			tag       <= sram_cmd_pkg::INIT;
			busy      <= 1'b1;					// busy until quad mode is entered
			cs_n      <= 1'b1;
			lanes     <= '0;					// all lanes released
			cnt       <= '0;
			addr_idx  <= '0;
			dummy_cnt <= '0;
		end else begin
			case (state)
				sram_cmd_pkg::INIT: begin
					if (cs_n) begin
						cs_n  <= 1'b0;			// wake the device
						cnt   <= 4'd1;
						tag   <= sram_cmd_pkg::INIT;	// come back here to send 0x38
						state <= sram_cmd_pkg::CS_SETUP;
					end else begin
						shift <= sram_cmd_pkg::OP_QUAD_ENTER;
						cnt   <= 4'd8;			// one bit per cycle
						tag   <= sram_cmd_pkg::HANGUP;
						state <= sram_cmd_pkg::SEND_SERIAL;
					end
				end
				sram_cmd_pkg::CS_SETUP: begin
				end
				sram_cmd_pkg::SEND_SERIAL: begin
					if (phase.drive_edge) begin
						lanes.oe   <= 4'b0001;	// device still in spi mode
						lanes.dout <= {3'b000, shift[7]};
						shift      <= {shift[6:0], 1'b0};
					end
				end
				sram_cmd_pkg::SEND_QUAD: begin
					if (phase.drive_edge) begin
						lanes.oe   <= 4'b1111;
						lanes.dout <= shift[7:4];	// high nibble first
						shift      <= {shift[3:0], 4'h0};
					end
				end
				sram_cmd_pkg::RECV_QUAD: begin
					if (phase.drive_edge) begin
						lanes.oe <= 4'b0000;	// turn the bus around
					end
					if (phase.sample_edge) begin
						shift <= {shift[3:0], din};
					end
				end
				sram_cmd_pkg::IDLE: begin
					if (req_valid) begin
						req_q    <= req;
						busy     <= 1'b1;
						cs_n     <= 1'b0;
						cnt      <= 4'd1;		// one setup cycle
						addr_idx <= IDX_W'(ADDR_BYTES - 1);
						tag      <= req.is_write ? sram_cmd_pkg::START_WRITE :
							sram_cmd_pkg::START_READ;
						state    <= sram_cmd_pkg::CS_SETUP;
					end
				end
				sram_cmd_pkg::START_WRITE: begin
					shift <= sram_cmd_pkg::OP_WRITE;
					cnt   <= 4'd2;
					tag   <= sram_cmd_pkg::ADDR_WRITE;
					state <= sram_cmd_pkg::SEND_QUAD;
				end
				sram_cmd_pkg::START_READ: begin
					shift <= sram_cmd_pkg::OP_READ;
					cnt   <= 4'd2;
					tag   <= sram_cmd_pkg::ADDR_READ;
					state <= sram_cmd_pkg::SEND_QUAD;
				end
				sram_cmd_pkg::ADDR_WRITE, sram_cmd_pkg::ADDR_READ: begin
					shift    <= addr_byte;
					cnt      <= 4'd2;
					addr_idx <= addr_idx - 1'b1;
					state    <= sram_cmd_pkg::SEND_QUAD;
					if (addr_idx != '0) begin
						tag <= state;			// more address bytes
					end else if (state == sram_cmd_pkg::ADDR_WRITE) begin
						tag <= sram_cmd_pkg::DATA_WRITE;
					end else begin
						tag       <= sram_cmd_pkg::DATA_READ;
						// one extra: first DATA_READ entry follows the address, not a receive
						dummy_cnt <= DUMMY_W'(`SRAM_DUMMY_BYTES + 1);
					end
				end
				sram_cmd_pkg::DATA_WRITE: begin
					if (!drained) begin
						shift <= head;			// popped this clock
						cnt   <= 4'd2;
						tag   <= sram_cmd_pkg::DATA_WRITE;
						state <= sram_cmd_pkg::SEND_QUAD;
					end else begin
						state <= sram_cmd_pkg::HANGUP;
					end
				end
				sram_cmd_pkg::DATA_READ: begin
					if (dummy_cnt != '0) begin
						dummy_cnt <= dummy_cnt - 1'b1;	// discard, fetch next
						cnt       <= 4'd2;
						tag       <= sram_cmd_pkg::DATA_READ;
						state     <= sram_cmd_pkg::RECV_QUAD;
					end else if (rd_last) begin
						state <= sram_cmd_pkg::HANGUP;
					end else begin
						cnt   <= 4'd2;
						tag   <= sram_cmd_pkg::DATA_READ;
						state <= sram_cmd_pkg::RECV_QUAD;
					end
				end
				sram_cmd_pkg::HANGUP: begin
					if (!cs_n) begin
						cs_n     <= 1'b1;
						lanes.oe <= 4'b0000;
						cnt      <= 4'd2;		// two idle spi cycles
					end else if (phase.sample_edge) begin
						if (cnt == 4'd1) begin
							busy  <= 1'b0;
							state <= sram_cmd_pkg::IDLE;
						end else begin
							cnt <= cnt - 4'd1;
						end
					end
				end
				default: begin
					state <= sram_cmd_pkg::HANGUP;	// illegal code, end cleanly
				end
			endcase
			// shared exit of the sub-states, one count per spi cycle
			if (in_sub && phase.sample_edge) begin
				if (cnt == 4'd1) begin
					state <= tag;
				end else begin
					cnt <= cnt - 4'd1;
				end
			end
		end
	end

endmodule

//--- hdl/spi_sram_top.sv
`timescale 1ns/1ps
`include "spi_sram_defs.svh"

module spi_sram_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [7:0]                  data_in,
	input  logic                        data_in_valid,	// push data_in
	output logic [7:0]                  data_out,		// fifo head
	input  logic                        data_out_read,	// pop the head
	input  logic                        write_cmd,		// one-cycle strobe
	input  logic                        read_cmd,		// one-cycle strobe
	input  logic [`SRAM_CNT_WIDTH-1:0]  read_cmd_size,
	input  logic [`SRAM_ADDR_WIDTH-1:0] address,
	input  logic [15:0]                 bauddiv,
	output logic                        busy,
	inout  wire  [3:0]                  sio,
	output logic                        cs_n,
	output logic                        sck
);

	sram_cmd_pkg::sram_req_t req;
	logic req_valid;
	qspi_bus_pkg::phase_t phase;
	qspi_bus_pkg::lane_drive_t lanes;
	logic run;
	logic owner;
	logic eng_push;
	logic [7:0] eng_data;
	logic eng_pop;
	logic rewind_rd;
	logic clear_wr;
	logic [7:0] head;
	logic [`SRAM_CNT_WIDTH-1:0] count;
	logic drained;

	assign req.addr     = address;
	assign req.size     = read_cmd_size;
	assign req.is_write = write_cmd;				// write wins if both strobe
	assign req_valid    = write_cmd || read_cmd;
	assign data_out     = head;

	for (genvar i = 0; i < 4; i++) begin : g_sio
		assign sio[i] = lanes.oe[i] ? lanes.dout[i] : 1'bz;
	end

	qspi_phase_gen qspi_phase_gen_i (
		.clk(clk), .rst_n(rst_n), .run(run), .bauddiv(bauddiv),
		.phase(phase), .sck(sck)
	);

	burst_fifo burst_fifo_i (
		.clk(clk), .rst_n(rst_n), .owner(owner),
		.push(data_in_valid), .push_data(data_in), .pop(data_out_read),
		.eng_push(eng_push), .eng_data(eng_data), .eng_pop(eng_pop),
		.rewind_rd(rewind_rd), .clear_wr(clear_wr),
		.head(head), .count(count), .drained(drained)
	);

	spi_sram spi_sram_i (
		.clk(clk), .rst_n(rst_n), .req(req), .req_valid(req_valid), .busy(busy),
		.phase(phase), .run(run), .lanes(lanes), .cs_n(cs_n), .din(sio),
		.owner(owner), .eng_push(eng_push), .eng_data(eng_data), .eng_pop(eng_pop),
		.rewind_rd(rewind_rd), .clear_wr(clear_wr),
		.head(head), .count(count), .drained(drained)
	);

endmodule

//--- dv/qspi_sram_model.sv
`timescale 1ns/1ps

module qspi_sram_model (
	input logic      cs_n,
	input logic      sck,
	inout wire [3:0] sio
);

	logic [7:0] mem [65536];		// 64 KiB array
	logic quad;						// device is in quad mode
	logic quad_seen;				// 0x38 arrived serially on lane 0
	int edges;						// rising sck edges since cs_n fell, edge 0 is setup
	int nib;						// read nibbles since the address ended
	logic [7:0] sh;					// incoming shift register
	logic [7:0] opcode;
	logic [15:0] ptr;				// burst address, wraps at 64 KiB
	logic reading;					// read data phase
	logic drive_en;					// model owns the bus
	logic [3:0] out_nib;
	logic [7:0] cur;

	assign sio = (!cs_n && drive_en) ? out_nib : 4'bzzzz;

	initial begin
		for (int a = 0; a < 65536; a++) begin
			mem[a] = {a[3:0], a[15:12]} ^ a[11:4];	// pattern uses every address bit
		end
		quad      = 1'b0;
		quad_seen = 1'b0;
		reading   = 1'b0;
		drive_en  = 1'b0;
		out_nib   = 4'h0;
		edges     = 0;
		nib       = 0;
	end

	always @(negedge cs_n) begin
		edges    = 0;				// new transaction
		reading  = 1'b0;
		drive_en = 1'b0;
		nib      = 0;
	end

	// sample just after the rising edge so lanes have settled
	always @(posedge sck) begin
		#1;
		if (!cs_n) begin
			if (reading) begin
				drive_en = 1'b1;	// controller let go of the bus in the previous low phase
			end else if (!quad) begin
				if (edges > 0) sh = {sh[6:0], sio[0]};
				if (edges == 8 && sh == 8'h38) begin
					quad      = 1'b1;
					quad_seen = 1'b1;
				end
			end else if (edges > 0) begin
				sh = {sh[3:0], sio};
				if (edges == 2) opcode = sh;
				else if (edges == 4) ptr[15:8] = sh;	// address high byte first
				else if (edges == 6) begin
					ptr[7:0] = sh;
					reading  = (opcode == 8'h03);
					nib      = 0;
				end else if (edges > 6 && edges % 2 == 0 && opcode == 8'h02) begin
					mem[ptr] = sh;
					ptr      = ptr + 16'd1;
				end
			end
			edges++;
		end
	end

	// nibbles 1 and 2 are the dummy byte, then data high nibble first
	always @(negedge sck) begin
		if (!cs_n && reading) begin
			nib++;
			if (nib >= 3) begin
				cur     = mem[16'(ptr + 16'((nib - 3) / 2))];
				out_nib = (nib % 2 == 1) ? cur[7:4] : cur[3:0];
			end
		end
	end

endmodule

//--- dv/tb_spi_sram.sv
`timescale 1ns/1ps
`include "spi_sram_defs.svh"

module tb_spi_sram;

	localparam int N_XFER = 120;	// transfers in the whole run including write-backs
	localparam int MAX_DIV = 5;		// slowest bauddiv used
	localparam longint LIMIT_NS = 2 * longint'(N_XFER) * 8 * (MAX_DIV + 1) *
		(`SRAM_FIFO_DEPTH + 8) * 40;

	logic clk;
	logic rst_n;
	logic [7:0] data_in;
	logic data_in_valid;
	logic [7:0] data_out;
	logic data_out_read;
	logic write_cmd;
	logic read_cmd;
	logic [`SRAM_CNT_WIDTH-1:0] read_cmd_size;
	logic [15:0] address;
	logic [15:0] bauddiv;
	logic busy;
	logic cs_n;
	logic sck;
	wire [3:0] sio;

	logic [7:0] shadow [65536];		// mirror of every byte written
	logic [7:0] wr_data [$];		// bytes for the next write burst
	logic [31:0] lfsr;
	logic cmp_on;					// compare each pop while high
	logic [15:0] cmp_base;
	logic [15:0] cmp_ofs;
	int cmp_errs;
	int chk_errs;
	int tests_pass;
	int tests_fail;

	spi_sram_top spi_sram_top_i (
		.clk(clk), .rst_n(rst_n), .data_in(data_in), .data_in_valid(data_in_valid),
		.data_out(data_out), .data_out_read(data_out_read), .write_cmd(write_cmd),
		.read_cmd(read_cmd), .read_cmd_size(read_cmd_size), .address(address),
		.bauddiv(bauddiv), .busy(busy), .sio(sio), .cs_n(cs_n), .sck(sck)
	);

	qspi_sram_model model_i (.cs_n(cs_n), .sck(sck), .sio(sio));

	always #20 clk = ~clk;			// 40 ns period

	function automatic logic [7:0] expected_byte(input logic [15:0] a);
		return shadow[a];
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);	// galois taps 32 22 2 1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	// compare each popped byte with the shadow at base plus offset
	always @(posedge clk) begin
		if (!cmp_on) begin
			cmp_ofs <= 16'd0;
		end else if (data_out_read) begin
			if (data_out !== expected_byte(cmp_base + cmp_ofs)) begin
				$display("error at %0t ns: data_out expected %02h actual %02h (address %04h)",
					$time, expected_byte(cmp_base + cmp_ofs), data_out, cmp_base + cmp_ofs);
				cmp_errs++;
			end
			cmp_ofs <= cmp_ofs + 16'd1;
		end
	end

	initial begin
		#(LIMIT_NS);
		$display("controller hung: busy did not drop within %0d ns", LIMIT_NS);
		$display("Regression failed");
		$finish;
	end

	task automatic wait_idle;
		@(negedge clk);
		while (busy) @(negedge clk);	// busy falls after the hangup cycles
	endtask

	task automatic write_burst(input logic [15:0] a);
		for (int i = 0; i < wr_data.size(); i++) begin
			@(negedge clk);
			data_in       = wr_data[i];
			data_in_valid = 1'b1;
			if (i < `SRAM_FIFO_DEPTH) shadow[a + 16'(i)] = wr_data[i];	// rest is dropped
		end
		@(negedge clk);
		data_in_valid = 1'b0;
		address       = a;
		write_cmd     = 1'b1;
		@(negedge clk);
		write_cmd = 1'b0;
		wait_idle();
	endtask

	// read n bytes then pop each one and write the lot back to empty the fifo
	task automatic read_burst(input logic [15:0] a, input int n);
		logic [7:0] last;
		@(negedge clk);
		address       = a;
		read_cmd_size = `SRAM_CNT_WIDTH'(n);
		read_cmd      = 1'b1;
		@(negedge clk);
		read_cmd = 1'b0;
		wait_idle();
		if (spi_sram_top_i.burst_fifo_i.count != `SRAM_CNT_WIDTH'(n)) begin
			$display("error at %0t ns: count expected %0d actual %0d", $time, n,
				spi_sram_top_i.burst_fifo_i.count);
			chk_errs++;
		end
		cmp_base = a;
		cmp_on   = 1'b1;
		repeat (n) begin
			@(negedge clk);
			data_out_read = 1'b1;
		end
		@(negedge clk);
		data_out_read = 1'b0;
		cmp_on        = 1'b0;
		last          = data_out;
		repeat (2) begin
			@(negedge clk);
			data_out_read = 1'b1;			// pops past the end are ignored
		end
		@(negedge clk);
		data_out_read = 1'b0;
		if (data_out !== last) begin
			$display("error at %0t ns: data_out expected %02h actual %02h after extra pops",
				$time, last, data_out);
			chk_errs++;
		end
		wr_data.delete();
		write_burst(a);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (cmp_errs + chk_errs == errs_before) begin
			tests_pass++;
			$display("test %s: pass", name);
		end else begin
			tests_fail++;
			$display("test %s: FAIL", name);
		end
	endtask

	task automatic fixed_pair(input logic [15:0] a);
		wr_data = {8'h11, 8'h22, 8'h33, 8'h44, 8'ha5, 8'h5a, 8'hf0, 8'h0f};
		write_burst(a);
		read_burst(a, 8);
	endtask

	initial begin
		int e;
		int n;
		logic [31:0] r;
		logic [15:0] a;
		clk = 1'b0;
		rst_n = 1'b0;
		data_in = 8'h00;
		data_in_valid = 1'b0;
		data_out_read = 1'b0;
		write_cmd = 1'b0;
		read_cmd = 1'b0;
		read_cmd_size = '0;
		address = 16'h0000;
		bauddiv = 16'd1;
		lfsr = 32'hb3c2;
		cmp_on = 1'b0;
		cmp_base = 16'h0000;
		cmp_errs = 0;
		chk_errs = 0;
		tests_pass = 0;
		tests_fail = 0;
		for (int i = 0; i < 65536; i++) begin
			shadow[i] = {i[3:0], i[15:12]} ^ i[11:4];	// power-up content of the sram
		end
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		e = 0;
		wait_idle();
		if (!model_i.quad_seen) begin
			$display("the sram never saw quad entry 0x38 on lane 0");
			chk_errs++;
		end
		if (cs_n !== 1'b1) begin
			$display("error at %0t ns: cs_n expected 1 actual %b", $time, cs_n);
			chk_errs++;
		end
		finish_test("init", e);

		e = cmp_errs + chk_errs;
		fixed_pair(16'h0100);
		finish_test("fixed_burst", e);

		e = cmp_errs + chk_errs;
		repeat (20) begin
			rand_bits(16, r);
			a = r[15:0];
			rand_bits(5, r);
			n = int'(r[4:0]) + 1;		// 1 to depth
			wr_data.delete();
			for (int i = 0; i < n; i++) begin
				rand_bits(8, r);
				wr_data.push_back(r[7:0]);
			end
			write_burst(a);
			read_burst(a, n);
			read_burst(a - 16'd8, 20);	// straddles the burst edge
		end
		finish_test("random_bursts", e);

		e = cmp_errs + chk_errs;
		read_burst(16'h0100, 5);
		finish_test("read_size", e);

		e = cmp_errs + chk_errs;
		wr_data.delete();
		for (int i = 0; i < `SRAM_FIFO_DEPTH + 8; i++) begin
			rand_bits(8, r);
			wr_data.push_back(r[7:0]);
		end
		write_burst(16'h2000);
		read_burst(16'h2000, `SRAM_FIFO_DEPTH);
		read_burst(16'h2000 + 16'(`SRAM_FIFO_DEPTH), 1);	// untouched by the overflow
		finish_test("overflow", e);

		e = cmp_errs + chk_errs;
		bauddiv = 16'd0;
		fixed_pair(16'h0300);			// own address per divider
		bauddiv = 16'd1;
		fixed_pair(16'h0400);
		bauddiv = 16'd5;
		fixed_pair(16'h0500);
		finish_test("bauddiv_sweep", e);

		$display("%0d tests passed, %0d tests failed, %0d errors", tests_pass, tests_fail,
			cmp_errs + chk_errs);
		if (tests_fail == 0 && cmp_errs + chk_errs == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
hdl/qspi_bus_pkg.sv
hdl/sram_cmd_pkg.sv
hdl/qspi_phase_gen.sv
hdl/burst_fifo.sv
hdl/spi_sram.sv
hdl/spi_sram_top.sv
dv/qspi_sram_model.sv
dv/tb_spi_sram.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it, and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing -f vlog.f --top-module tb_spi_sram -o tb_sim > build.log 2>&1 \
	|| { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && echo "simulation PASS" \
	|| { echo "simulation FAIL, see sim.log"; exit 1; }
